/* build.f */
src/hc_pkg.sv
src/han_carlson_tree.sv
src/ling_adder.sv
src/addsub_unit.sv
src/wb_addsub_regs.sv
src/wb_addsub_top.sv
verif/tb_wb_addsub.sv

/* src/addsub_unit.sv */
// Add/subtract operation unit with registered result and status flags
`default_nettype none
`timescale 1ns/10ps

module addsub_unit
	import hc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic op_valid,
	input op_req_t op_req,
	output op_rsp_t op_rsp
);

	logic sub;
	logic cin;
	logic [DATA_W-1:0] b_in;
	logic [DATA_W-1:0] sum;
	logic cout;
	logic ovf;

	assign sub = (op_req.op == OP_SUB) || (op_req.op == OP_SBB);
	assign b_in = sub ? ~op_req.b : op_req.b;

	// Borrow is the inverse of the stored carry, so SBB also takes the carry
	always_comb begin
		case (op_req.op)
			OP_ADD: cin = 1'b0;
			OP_SUB: cin = 1'b1;
			default: cin = op_rsp.carry;
		endcase
	end

	ling_adder u_adder (
		.a(op_req.a),
		.b(b_in),
		.cin(cin),
		.sum(sum),
		.cout(cout)
	);

	// Same-sign inputs giving a different-sign sum
	assign ovf = (op_req.a[DATA_W-1] == b_in[DATA_W-1]) &&
		(sum[DATA_W-1] != op_req.a[DATA_W-1]);

	always_ff @(posedge clk) begin
		if (rst) begin
			op_rsp <= '0;
		end else if (op_valid) begin
			op_rsp.sum <= sum;
			op_rsp.carry <= cout;
			op_rsp.zero <= (sum == '0);
			op_rsp.ovf <= ovf;
			op_rsp.done <= 1'b1;
		end
	end

	a_valid_known: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(op_valid)
	);

	// done is sticky until reset
	a_done_sticky: assert property (
		@(posedge clk) disable iff (rst)
		op_rsp.done |=> op_rsp.done
	);

endmodule

`default_nettype wire

/* src/han_carlson_tree.sv */
// Han-Carlson prefix tree computing Ling pseudo-carries and true carries
`default_nettype none
`timescale 1ns/10ps

module han_carlson_tree
	import hc_pkg::*;
(
	input logic [DATA_W:0] p,
	input logic [DATA_W:0] g,
	output logic [DATA_W-1:0] h,
	output logic [DATA_W-1:0] c
);

	// Node j covers tree index 2j+1, the odd positions of the {ab, cin} vector
	logic [HC_NODES-1:0] h_st [HC_STAGES];
	logic [HC_NODES-1:0] i_st [HC_STAGES];

	// First stage, pairs of adjacent bits
	for (genvar j = 0; j < HC_NODES; j++) begin : g_pre
		if (j == 0) begin : g_rgry
			assign h_st[0][j] = rgry_h(g[1], g[0]);
			// No group propagate below the carry-in
			assign i_st[0][j] = 1'b0;
		end else begin : g_rblk
			assign h_st[0][j] = rblk_h(g[2*j+1], g[2*j]);
			assign i_st[0][j] = rblk_i(p[2*j], p[2*j-1]);
		end
	end

	// Sparse tree, span doubles each stage
	for (genvar s = 1; s < HC_STAGES; s++) begin : g_stage
		for (genvar j = 0; j < HC_NODES; j++) begin : g_node
			if (j < (1 << (s - 1))) begin : g_pass
				assign h_st[s][j] = h_st[s-1][j];
				assign i_st[s][j] = i_st[s-1][j];
			end else if (j < (2 << (s - 1))) begin : g_grey
				// Partner already reaches position zero
				assign h_st[s][j] = grey_g(h_st[s-1][j], i_st[s-1][j],
					h_st[s-1][j-(1 << (s - 1))]);
				assign i_st[s][j] = i_st[s-1][j];
			end else begin : g_black
				assign h_st[s][j] = black_g(h_st[s-1][j], i_st[s-1][j],
					h_st[s-1][j-(1 << (s - 1))]);
				assign i_st[s][j] = black_p(i_st[s-1][j],
					i_st[s-1][j-(1 << (s - 1))]);
			end
		end
	end

	// Odd tree outputs direct, even positions from one extra grey row
	for (genvar j = 0; j < HC_NODES; j++) begin : g_out
		assign h[2*j] = h_st[HC_STAGES-1][j];
		assign h[2*j+1] = grey_g(g[2*j+2], p[2*j+1], h_st[HC_STAGES-1][j]);
	end

	// Carry into each bit from the previous propagate and pseudo-carry
	assign c[0] = g[0];
	for (genvar i = 1; i < DATA_W; i++) begin : g_carry
		assign c[i] = p[i] & h[i-1];
	end

endmodule

`default_nettype wire

/* src/hc_pkg.sv */
// Shared widths, register map, opcodes, bus structs and prefix-cell functions for the add/sub accelerator
`default_nettype none

package hc_pkg;

	localparam int DATA_W = 20;
	localparam int WB_DW = 32;
	localparam int WB_AW = 4;

	// Han-Carlson tree shape, one node per odd/even bit pair
	localparam int HC_NODES = DATA_W / 2;
	localparam int HC_STAGES = $clog2(HC_NODES) + 1;

	// Word indices, selected by adr[3:2]
	localparam logic [1:0] REG_OPA = 2'd0;
	localparam logic [1:0] REG_OPB = 2'd1;
	localparam logic [1:0] REG_CTRL = 2'd2;
	localparam logic [1:0] REG_RESULT = 2'd3;

	// Flag positions in the RESULT word
	localparam int RES_CARRY_BIT = 20;
	localparam int RES_ZERO_BIT = 21;
	localparam int RES_OVF_BIT = 22;
	localparam int RES_DONE_BIT = 23;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_ADC = 2'd2,
		OP_SBB = 2'd3
	} opcode_t;

	typedef struct packed {
		opcode_t op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} op_req_t;

	// Field order mirrors the RESULT word layout
	typedef struct packed {
		logic done;
		logic ovf;
		logic zero;
		logic carry;
		logic [DATA_W-1:0] sum;
	} op_rsp_t;

	function automatic logic grey_g(input logic g_hi, input logic p_hi, input logic g_lo);
		return g_hi | (p_hi & g_lo);
	endfunction

	function automatic logic black_g(input logic g_hi, input logic p_hi, input logic g_lo);
		return grey_g(g_hi, p_hi, g_lo);
	endfunction

	function automatic logic black_p(input logic p_hi, input logic p_lo);
		return p_hi & p_lo;
	endfunction

	// Reduced cells for the Ling first stage
	function automatic logic rgry_h(input logic g_hi, input logic g_lo);
		return g_hi | g_lo;
	endfunction

	function automatic logic rblk_h(input logic g_hi, input logic g_lo);
		return rgry_h(g_hi, g_lo);
	endfunction

	function automatic logic rblk_i(input logic p_hi, input logic p_lo);
		return p_hi & p_lo;
	endfunction

endpackage

`default_nettype wire

/* src/ling_adder.sv */
// Ling-form parallel-prefix adder with carry in and carry out
`default_nettype none
`timescale 1ns/10ps

module ling_adder
	import hc_pkg::*;
(
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	input logic cin,
	output logic [DATA_W-1:0] sum,
	output logic cout
);

	logic [DATA_W:0] p;
	logic [DATA_W:0] g;
	logic [DATA_W-1:0] h;
	logic [DATA_W-1:0] c;

	// Carry-in sits at position zero with a forced propagate
	assign p = {a | b, 1'b1};
	assign g = {a & b, cin};

	han_carlson_tree u_tree (
		.p(p),
		.g(g),
		.h(h),
		.c(c)
	);

	// Ling post-computation
	// when g is set the sum bit is just the incoming carry
	assign sum = (p[DATA_W:1] ^ h) | (g[DATA_W:1] & c);
	assign cout = p[DATA_W] & h[DATA_W-1];

endmodule

`default_nettype wire

/* src/wb_addsub_regs.sv */
// Wishbone classic register block holding operands and opcode, reading back the result
`default_nettype none
`timescale 1ns/10ps

module wb_addsub_regs
	import hc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [WB_AW-1:0] adr,
	input logic [WB_DW-1:0] dat_w,
	output logic [WB_DW-1:0] dat_r,
	output logic ack,
	output op_req_t op_req,
	output logic op_valid,
	input op_rsp_t op_rsp
);

	logic [WB_AW-3:0] word;
	logic req;
	logic wr_en;
	logic [DATA_W-1:0] opa_q;
	logic [DATA_W-1:0] opb_q;
	opcode_t op_q;
	logic [WB_DW-1:0] rd_data;

	assign word = adr[WB_AW-1:2];

	// Request is ignored in the cycle its ack is out
	assign req = cyc && stb && !ack;
	assign wr_en = req && we;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			op_valid <= 1'b0;
		end else begin
			ack <= req;
			op_valid <= wr_en && (word == REG_CTRL);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			opa_q <= '0;
			opb_q <= '0;
			op_q <= OP_ADD;
		end else if (wr_en) begin
			case (word)
				REG_OPA: opa_q <= dat_w[DATA_W-1:0];
				REG_OPB: opb_q <= dat_w[DATA_W-1:0];
				REG_CTRL: op_q <= opcode_t'(dat_w[1:0]);
				default: ;
			endcase
		end
	end

	always_comb begin
		rd_data = '0;
		case (word)
			REG_OPA: rd_data[DATA_W-1:0] = opa_q;
			REG_OPB: rd_data[DATA_W-1:0] = opb_q;
			REG_CTRL: rd_data[1:0] = op_q;
			REG_RESULT: begin
				rd_data[DATA_W-1:0] = op_rsp.sum;
				rd_data[RES_CARRY_BIT] = op_rsp.carry;
				rd_data[RES_ZERO_BIT] = op_rsp.zero;
				rd_data[RES_OVF_BIT] = op_rsp.ovf;
				rd_data[RES_DONE_BIT] = op_rsp.done;
			end
			default: ;
		endcase
	end

	// Read data is captured with the ack
	always_ff @(posedge clk) begin
		if (req && !we) begin
			dat_r <= rd_data;
		end
	end

	assign op_req = '{op: op_q, a: opa_q, b: opb_q};

	a_ack_single: assert property (
		@(posedge clk) disable iff (rst)
		ack |=> !ack
	);

	a_ack_after_cyc: assert property (
		@(posedge clk) disable iff (rst)
		ack |-> $past(cyc)
	);

endmodule

`default_nettype wire

/* src/wb_addsub_top.sv */
// Top level of the Wishbone add/subtract accelerator
`default_nettype none
`timescale 1ns/10ps

module wb_addsub_top
	import hc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [WB_AW-1:0] adr,
	input logic [WB_DW-1:0] dat_w,
	output logic [WB_DW-1:0] dat_r,
	output logic ack
);

	op_req_t op_req;
	logic op_valid;
	op_rsp_t op_rsp;

	wb_addsub_regs u_regs (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.op_req(op_req),
		.op_valid(op_valid),
		.op_rsp(op_rsp)
	);

	addsub_unit u_unit (
		.clk(clk),
		.rst(rst),
		.op_valid(op_valid),
		.op_req(op_req),
		.op_rsp(op_rsp)
	);

endmodule

`default_nettype wire

/* verif/tb_wb_addsub.sv */
// Self-checking testbench for the Wishbone add/subtract accelerator against a reference model
`default_nettype none
`timescale 1ns/10ps

module tb_wb_addsub
	import hc_pkg::*;
();

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [WB_AW-1:0] adr;
	logic [WB_DW-1:0] dat_w;
	logic [WB_DW-1:0] dat_r;
	logic ack;

	// Carry as the model expects the DUT to have stored it
	logic model_carry;
	int req_count = 0;
	int ack_count = 0;

	wb_addsub_top dut (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Acks sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && ack) begin
			ack_count++;
		end
	end

	task automatic check(input string name, input logic [WB_DW-1:0] actual,
		input logic [WB_DW-1:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", reason);
	endtask

	// Starts a request and returns once its ack is seen, leaving stb high
	task automatic bus_access(input logic wr, input logic [1:0] word,
		input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
		int waited;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= {word, 2'b00};
		dat_w <= wdata;
		req_count++;
		// An ack from the previous request must be gone by now
		@(negedge clk);
		if (ack) begin
			abort_run("Ack stayed high for more than one cycle");
		end
		waited = 0;
		while (!ack) begin
			waited++;
			if (waited > 20) begin
				abort_run($sformatf("Timed out waiting for ack on register word %0d", word));
			end
			@(negedge clk);
		end
		rdata = dat_r;
	endtask

	task automatic bus_release();
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		@(negedge clk);
		if (ack) begin
			abort_run("Ack stayed high after the request ended");
		end
	endtask

	task automatic wb_write(input logic [1:0] word, input logic [WB_DW-1:0] data);
		logic [WB_DW-1:0] unused;
		bus_access(1'b1, word, data, unused);
		bus_release();
	endtask

	task automatic wb_read(input logic [1:0] word, output logic [WB_DW-1:0] data);
		bus_access(1'b0, word, '0, data);
		bus_release();
	endtask

	// Expected RESULT word, updates the stored carry
	task automatic model_op(input opcode_t op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, output logic [WB_DW-1:0] word);
		logic [DATA_W-1:0] nb;
		logic [DATA_W:0] full;
		int sa;
		int sb;
		int sr;
		nb = ~b;
		sa = $signed(a);
		sb = $signed(b);
		case (op)
			OP_ADD: begin
				full = {1'b0, a} + {1'b0, b};
				sr = sa + sb;
			end
			OP_SUB: begin
				full = {1'b0, a} + {1'b0, nb} + 1;
				sr = sa - sb;
			end
			OP_ADC: begin
				full = {1'b0, a} + {1'b0, b} + model_carry;
				sr = sa + sb + model_carry;
			end
			default: begin
				// Borrow is the inverted stored carry
				full = {1'b0, a} + {1'b0, nb} + model_carry;
				sr = sa - sb - (model_carry ? 0 : 1);
			end
		endcase
		word = '0;
		word[DATA_W-1:0] = full[DATA_W-1:0];
		word[RES_CARRY_BIT] = full[DATA_W];
		word[RES_ZERO_BIT] = (full[DATA_W-1:0] == '0);
		word[RES_OVF_BIT] = (sr > (1 << (DATA_W - 1)) - 1) || (sr < -(1 << (DATA_W - 1)));
		word[RES_DONE_BIT] = 1'b1;
		model_carry = full[DATA_W];
	endtask

	function automatic logic [DATA_W-1:0] pick_operand();
		logic [DATA_W-1:0] val;
		case ($urandom % 8)
			0: val = '0;
			1: val = '1;
			2: val = {1'b0, {(DATA_W - 1){1'b1}}};
			3: val = {1'b1, {(DATA_W - 1){1'b0}}};
			4: val = 1;
			default: val = $urandom;
		endcase
		return val;
	endfunction

	// Result read goes out right after the CTRL ack
	task automatic run_op(input opcode_t op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, output logic [WB_DW-1:0] result);
		logic [WB_DW-1:0] unused;
		logic [WB_DW-1:0] expected;
		wb_write(REG_OPA, a);
		wb_write(REG_OPB, b);
		bus_access(1'b1, REG_CTRL, {30'd0, op}, unused);
		bus_access(1'b0, REG_RESULT, '0, result);
		bus_release();
		model_op(op, a, b, expected);
		check("RESULT", result, expected);
	endtask

	initial begin
		logic [WB_DW-1:0] rd;
		logic [WB_DW-1:0] wr;
		opcode_t op;
		int seed_draw;
		seed_draw = $urandom(32'hfbfdfdd6);
		rst <= 1'b1;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		dat_w <= '0;
		model_carry = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// Everything reads zero out of reset
		for (int i = 0; i < 4; i++) begin
			wb_read(2'(i), rd);
			check($sformatf("reset value of word %0d", i), rd, '0);
		end

		// Operand readback and ignored RESULT write
		wr = $urandom;
		wb_write(REG_OPA, wr);
		wb_read(REG_OPA, rd);
		check("OPA", rd, {12'd0, wr[DATA_W-1:0]});
		wr = $urandom;
		wb_write(REG_OPB, wr);
		wb_read(REG_OPB, rd);
		check("OPB", rd, {12'd0, wr[DATA_W-1:0]});
		wb_write(REG_RESULT, 32'hffff_ffff);
		wb_read(REG_RESULT, rd);
		check("RESULT after write", rd, '0);

		for (int i = 0; i < 200; i++) begin
			op = ($urandom % 2) ? OP_SUB : OP_ADD;
			run_op(op, pick_operand(), pick_operand(), rd);
			if (i % 25 == 0) begin
				wb_read(REG_CTRL, rd);
				check("CTRL", rd, {30'd0, op});
			end
		end

		// Carry chains, each seeded by a plain add or subtract
		for (int chain = 0; chain < 10; chain++) begin
			op = ($urandom % 2) ? OP_SUB : OP_ADD;
			run_op(op, pick_operand(), pick_operand(), rd);
			for (int i = 0; i < 12; i++) begin
				op = ($urandom % 2) ? OP_SBB : OP_ADC;
				run_op(op, pick_operand(), pick_operand(), rd);
			end
		end

		// Full-length ripple, done + zero + carry
		run_op(OP_ADD, '1, 20'd1, rd);
		check("RESULT all ones plus one", rd, 32'h00b0_0000);
		// Done only, sum all ones, borrow out
		run_op(OP_SUB, '0, 20'd1, rd);
		check("RESULT zero minus one", rd, 32'h008f_ffff);

		check("ack count", ack_count, req_count);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
